/* vlog.f */
hw/fetch_geom_pkg.sv
hw/cache_geom_pkg.sv
hw/line_refill.sv
hw/icache.sv
hw/fetch_seq.sv
hw/fetch_top.sv
dv/bus_mem_model.sv
dv/fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= fetch_tb
RTL_TOP ?= fetch_top
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?=
PASS_MSG ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* dv/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb
	import fetch_geom_pkg::*;
	import cache_geom_pkg::*;
();

localparam int SWEEP_CYC = 512;
localparam int N_SEQ = 40;
localparam int N_HIT = 8;
localparam int N_BP = 24;
localparam int N_GROUPS = N_SEQ + N_HIT + 1 + N_BP;
localparam logic [PC_W-1:0] ALIAS_PC = 32'h0000_2050;	// line 5 plus 8192

logic wclk = 1'b0;
logic rst_i;
logic cyc_o, stb_o, ack_i;
logic [PC_W-1:0] adr_o;
logic [BUS_W-1:0] dat_i;
logic redirect_i, req_o, cack_i;
logic [PC_W-1:0] redirect_pc_i, grp_pc_o;
logic [INSN_W-1:0] insn0_o, insn1_o, insn2_o;
logic [1:0] bus_wait;

logic [31:0] lfsr_q = 32'h9f12_c84b;
logic [PC_W-1:0] exp_base, prev_base, refill_base;
int err_cnt = 0;
int pass_cnt = 0;
int fail_cnt = 0;
int word_cnt;
logic hit_phase, alias_seen, cyc_prev, full_prev;

always #50 wclk = ~wclk;

fetch_top fetch_top_inst (
	.wclk(wclk), .rst_i(rst_i), .cyc_o(cyc_o), .stb_o(stb_o), .adr_o(adr_o),
	.ack_i(ack_i), .dat_i(dat_i), .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
	.req_o(req_o), .cack_i(cack_i), .insn0_o(insn0_o), .insn1_o(insn1_o),
	.insn2_o(insn2_o), .grp_pc_o(grp_pc_o)
);

bus_mem_model bus_mem_model_inst (
	.wclk(wclk), .rst_i(rst_i), .cyc_i(cyc_o), .stb_i(stb_o), .adr_i(adr_o),
	.wait_i(bus_wait), .ack_o(ack_i), .dat_o(dat_i)
);

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic int rand_bits(input int n);
	int r;
	r = 0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
		r = (r << 1) | int'(lfsr_q[0]);
	end
	return r;
endfunction

function automatic logic [BUS_W-1:0] mem_word(input logic [31:0] addr);
	return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_3c3c;
endfunction

function automatic logic [LINE_W-1:0] expected_group(input logic [PC_W-1:0] base);
	logic [LINE_W-1:0] l;
	for (int w = 0; w < WORDS_PER_LINE; w++)
		l[w*BUS_W +: BUS_W] = mem_word(base + 32'(4 * w));	// offset 0 in the low bits
	return l;
endfunction

always @(posedge wclk) begin
	#3 bus_wait = 2'(rand_bits(2));
end

task automatic take_group(input int delay);
	logic [LINE_W-1:0] l;
	l = expected_group(exp_base);
	while (!req_o) begin
		@(posedge wclk);
		#1;
	end
	repeat (delay) begin
		@(posedge wclk);
		#1;
	end
	assert (req_o) else begin
		$display("%0t: req_o dropped before the consumer acked", $time);
		err_cnt++;
	end
	assert (grp_pc_o == exp_base) else begin
		$display("MISMATCH %0t grp_pc_o exp %h got %h", $time, exp_base, grp_pc_o);
		err_cnt++;
	end
	assert (insn0_o == l[39:0]) else begin
		$display("MISMATCH %0t insn0_o exp %h got %h", $time, l[39:0], insn0_o);
		err_cnt++;
	end
	assert (insn1_o == l[79:40]) else begin
		$display("MISMATCH %0t insn1_o exp %h got %h", $time, l[79:40], insn1_o);
		err_cnt++;
	end
	assert (insn2_o == l[119:80]) else begin
		$display("MISMATCH %0t insn2_o exp %h got %h", $time, l[119:80], insn2_o);
		err_cnt++;
	end
	cack_i = 1'b1;
	exp_base = exp_base + 32'd16;
	do begin
		@(posedge wclk);
		#1;
	end while (req_o);
	cack_i = 1'b0;
endtask

// called right after take_group, while req_o and cack_i are low
task automatic redirect_to(input logic [PC_W-1:0] pc);
	redirect_i = 1'b1;
	redirect_pc_i = pc;
	prev_base = exp_base;
	exp_base = {pc[PC_W-1:4], 4'h0};
	@(posedge wclk);
	#1 redirect_i = 1'b0;
endtask

task automatic report_test(input string name, input int mark);
	if (err_cnt == mark) begin
		pass_cnt++;
		$display("test %s: ok", name);
	end else begin
		fail_cnt++;
		$display("test %s: FAILED with %0d errors", name, err_cnt - mark);
	end
endtask

// bus rule monitor, samples late in the cycle
always @(posedge wclk) begin
	#2;
	if (rst_i) begin
		cyc_prev = 1'b0;
		full_prev = 1'b0;
		word_cnt = 0;
	end else begin
		assert (!stb_o || cyc_o) else begin
			$display("%0t: stb_o high outside cyc_o", $time);
			err_cnt++;
		end
		if (cyc_o && !cyc_prev) begin
			refill_base = {adr_o[PC_W-1:4], 4'h0};
			word_cnt = 0;
			if (refill_base == ALIAS_PC)
				alias_seen = 1'b1;
			assert (adr_o[3:0] == 4'h0 &&
				((refill_base - exp_base) <= 32 || (refill_base - prev_base) <= 32)) else begin
				$display("%0t: refill at %h is not the next expected line %h",
					$time, adr_o, exp_base);
				err_cnt++;
			end
			assert (!hit_phase) else begin
				$display("%0t: refill started on the hit path", $time);
				err_cnt++;
			end
			assert (!full_prev) else begin
				$display("%0t: refill started while both groups were full", $time);
				err_cnt++;
			end
		end
		if (stb_o && ack_i) begin
			assert (adr_o == refill_base + 32'(4 * word_cnt)) else begin
				$display("MISMATCH %0t adr_o exp %h got %h", $time,
					refill_base + 32'(4 * word_cnt), adr_o);
				err_cnt++;
			end
			word_cnt++;
		end
		if (!cyc_o && cyc_prev)
			assert (word_cnt == WORDS_PER_LINE) else begin
				$display("%0t: refill ended after %0d words", $time, word_cnt);
				err_cnt++;
			end
		cyc_prev = cyc_o;
		full_prev = &fetch_top_inst.fetch_seq_inst.grp_vld;
	end
end

initial begin
	#((N_GROUPS * 40 + SWEEP_CYC + 20) * 100);
	$display("watchdog expired before all groups arrived");
	$display("Simulation failed");
	$finish;
end

initial begin
	int mark;
	rst_i = 1'b1;
	cack_i = 1'b0;
	redirect_i = 1'b0;
	redirect_pc_i = '0;
	bus_wait = '0;
	exp_base = RESET_PC;
	prev_base = RESET_PC;
	refill_base = '0;
	hit_phase = 1'b0;
	alias_seen = 1'b0;
	repeat (10) @(posedge wclk);
	#1 rst_i = 1'b0;

	mark = err_cnt;
	@(posedge wclk);
	#1;
	assert (!req_o && !cyc_o) else begin
		$display("%0t: req_o or cyc_o high right after reset", $time);
		err_cnt++;
	end
	repeat (SWEEP_CYC) begin
		@(posedge wclk);
		#1;
		assert (!cyc_o) else begin
			$display("%0t: cyc_o high during the tag sweep", $time);
			err_cnt++;
		end
	end
	report_test("reset and sweep", mark);

	mark = err_cnt;
	repeat (N_SEQ) take_group(0);
	report_test("sequential stream", mark);

	mark = err_cnt;
	redirect_to(32'h0000_0007);	// low bits ignored
	@(posedge wclk);
	#1 hit_phase = 1'b1;
	repeat (N_HIT) take_group(0);
	hit_phase = 1'b0;
	report_test("hit path", mark);

	mark = err_cnt;
	redirect_to(ALIAS_PC);
	take_group(0);
	assert (alias_seen) else begin
		$display("%0t: aliased line was not refilled", $time);
		err_cnt++;
	end
	report_test("alias miss", mark);

	mark = err_cnt;
	redirect_to(32'h0000_01e0);	// cached lines first so both groups are full when misses start
	repeat (N_BP) take_group(rand_bits(3));
	report_test("back-pressure", mark);

	$display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
	if (err_cnt == 0)
		$display("Simulation completed successfully");
	else
		$display("Simulation failed");
	$finish;
end

endmodule

/* dv/bus_mem_model.sv */
`timescale 1ns/10ps

module bus_mem_model
	import cache_geom_pkg::*;
(
	input  logic wclk,
	input  logic rst_i,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic [TAG_LSB+TAG_W-1:0] adr_i,
	input  logic [1:0] wait_i,
	output logic ack_o,
	output logic [BUS_W-1:0] dat_o
);

logic [1:0] wait_cnt;
logic busy;

// memory contents are a fixed function of the byte address
function automatic logic [BUS_W-1:0] word_at(input logic [31:0] addr);
	return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_3c3c;
endfunction

always @(posedge wclk) begin
	#1;
	if (rst_i) begin
		ack_o = 1'b0;
		dat_o = '0;
		busy = 1'b0;
		wait_cnt = '0;
	end else if (ack_o) begin
		ack_o = 1'b0;	// one ack per word
	end else if (cyc_i && stb_i) begin
		if (!busy) begin
			busy = 1'b1;
			wait_cnt = wait_i;
		end
		if (wait_cnt == 0) begin
			ack_o = 1'b1;
			dat_o = word_at(adr_i);
			busy = 1'b0;
		end else
			wait_cnt = wait_cnt - 1'b1;
	end
end

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top
	import fetch_geom_pkg::*;
	import cache_geom_pkg::*;
(
	input  logic wclk,
	input  logic rst_i,
	output logic cyc_o,
	output logic stb_o,
	output logic [PC_W-1:0] adr_o,
	input  logic ack_i,
	input  logic [BUS_W-1:0] dat_i,
	input  logic redirect_i,
	input  logic [PC_W-1:0] redirect_pc_i,
	output logic req_o,
	input  logic cack_i,
	output logic [INSN_W-1:0] insn0_o,
	output logic [INSN_W-1:0] insn1_o,
	output logic [INSN_W-1:0] insn2_o,
	output logic [PC_W-1:0] grp_pc_o
);

logic miss;
logic hit;
logic lookup;
logic fill_we;
logic tag_clr;
logic [INDEX_W-1:0] clr_idx;
logic [PC_W-1:0] pc;
logic [LINE_W-1:0] line;

line_refill line_refill_inst (
	.wclk      (wclk),
	.rst_i     (rst_i),
	.miss_i    (miss),
	.miss_pc_i (pc),
	.ack_i     (ack_i),
	.cyc_o     (cyc_o),
	.stb_o     (stb_o),
	.adr_o     (adr_o),
	.fill_we_o (fill_we),
	.tag_clr_o (tag_clr),
	.clr_idx_o (clr_idx)
);

icache icache_inst (
	.wclk       (wclk),
	.fill_we_i  (fill_we),
	.fill_adr_i (adr_o),	// refill address doubles as the write address
	.fill_dat_i (dat_i),
	.tag_clr_i  (tag_clr),
	.clr_idx_i  (clr_idx),
	.lookup_i   (lookup),
	.pc_i       (pc),
	.line_o     (line),
	.hit_o      (hit),
	.miss_o     (miss)
);

fetch_seq fetch_seq_inst (
	.wclk          (wclk),
	.rst_i         (rst_i),
	.line_i        (line),
	.hit_i         (hit),
	.redirect_i    (redirect_i),
	.redirect_pc_i (redirect_pc_i),
	.cack_i        (cack_i),
	.pc_o          (pc),
	.lookup_o      (lookup),
	.req_o         (req_o),
	.insn0_o       (insn0_o),
	.insn1_o       (insn1_o),
	.insn2_o       (insn2_o),
	.grp_pc_o      (grp_pc_o)
);

endmodule

/* hw/fetch_seq.sv */
`timescale 1ns/10ps

module fetch_seq
	import fetch_geom_pkg::*;
(
	input  logic wclk,
	input  logic rst_i,
	input  logic [LINE_W-1:0] line_i,
	input  logic hit_i,
	input  logic redirect_i,
	input  logic [PC_W-1:0] redirect_pc_i,
	input  logic cack_i,
	output logic [PC_W-1:0] pc_o,
	output logic lookup_o,
	output logic req_o,
	output logic [INSN_W-1:0] insn0_o,
	output logic [INSN_W-1:0] insn1_o,
	output logic [INSN_W-1:0] insn2_o,
	output logic [PC_W-1:0] grp_pc_o
);

logic pc_vld;
logic [PC_W-1:LINE_OFS_W] pc_line;
logic front;	// index of the group offered to the consumer
logic [1:0] grp_vld;
logic [INSN_W-1:0] grp_insn [2][SLOTS];
logic [PC_W-1:0] grp_pc [2];
logic [INSN_W-1:0] slot_insn [SLOTS];
logic ld_sel;
logic load;
logic free_grp;

assign pc_o = {pc_line, {LINE_OFS_W{1'b0}}};
assign lookup_o = pc_vld & !(&grp_vld);

// front first, the other group when the front is taken
assign ld_sel = grp_vld[front] ? ~front : front;
assign load = hit_i & ~redirect_i;
assign free_grp = req_o & cack_i;

always_comb begin
	for (int s = 0; s < SLOTS; s++)
		slot_insn[s] = line_i[s*INSN_W +: INSN_W];
end

always_ff @(posedge wclk) begin
	if (rst_i) begin
		pc_vld <= 1'b0;
		pc_line <= RESET_PC[PC_W-1:LINE_OFS_W];
		front <= 1'b0;
		grp_vld <= '0;
		req_o <= 1'b0;
	end else begin
		pc_vld <= 1'b1;
		if (redirect_i) begin
			pc_line <= redirect_pc_i[PC_W-1:LINE_OFS_W];	// line base only
			grp_vld <= '0;
		end else begin
			if (free_grp) begin
				grp_vld[front] <= 1'b0;
				front <= ~front;
			end
			if (load) begin
				grp_vld[ld_sel] <= 1'b1;
				pc_line <= pc_line + 1'b1;
			end
		end
		// four-phase: raise only after ack has been seen low
		if (free_grp)
			req_o <= 1'b0;
		else if (!req_o && grp_vld[front] && !cack_i && !redirect_i)
			req_o <= 1'b1;
	end
end

always_ff @(posedge wclk) begin
	if (load) begin
		grp_insn[ld_sel] <= slot_insn;
		grp_pc[ld_sel] <= pc_o;
	end
end

assign insn0_o = grp_insn[front][0];
assign insn1_o = grp_insn[front][1];
assign insn2_o = grp_insn[front][2];
assign grp_pc_o = grp_pc[front];

endmodule

/* hw/icache.sv */
`timescale 1ns/10ps

module icache
	import fetch_geom_pkg::*;
	import cache_geom_pkg::*;
(
	input  logic wclk,
	input  logic fill_we_i,
	input  logic [PC_W-1:0] fill_adr_i,
	input  logic [BUS_W-1:0] fill_dat_i,
	input  logic tag_clr_i,
	input  logic [INDEX_W-1:0] clr_idx_i,
	input  logic lookup_i,
	input  logic [PC_W-1:0] pc_i,
	output logic [LINE_W-1:0] line_o,
	output logic hit_o,
	output logic miss_o
);

logic [LINE_W-1:0] data_mem [2**INDEX_W];
logic [TAG_W-1:0] tag_mem [2**INDEX_W];
logic [2**INDEX_W-1:0] tag_vld;
logic [INDEX_W-1:0] fill_idx;
logic [INDEX_W-1:0] rd_idx;
logic [INDEX_LSB-3:0] fill_word;
logic fill_last;
logic tag_match;

assign fill_idx = fill_adr_i[INDEX_LSB +: INDEX_W];
assign fill_word = fill_adr_i[INDEX_LSB-1:2];
assign fill_last = 32'(fill_word) == WORDS_PER_LINE - 1;
assign rd_idx = pc_i[INDEX_LSB +: INDEX_W];

always_ff @(posedge wclk) begin
	if (fill_we_i)
		data_mem[fill_idx][fill_word*BUS_W +: BUS_W] <= fill_dat_i;	// one 32-bit lane
end

always_ff @(posedge wclk) begin
	if (tag_clr_i)
		tag_vld[clr_idx_i] <= 1'b0;
	else if (fill_we_i)
		tag_vld[fill_idx] <= fill_last;	// a half written line never hits
	if (fill_we_i && fill_last)
		tag_mem[fill_idx] <= fill_adr_i[TAG_LSB +: TAG_W];
end

assign line_o = data_mem[rd_idx];
assign tag_match = tag_vld[rd_idx] && (tag_mem[rd_idx] == pc_i[TAG_LSB +: TAG_W]);

// valid bits are still being cleared during the sweep
assign hit_o = lookup_i & tag_match & ~tag_clr_i;
assign miss_o = lookup_i & ~hit_o;

endmodule

/* hw/line_refill.sv */
`timescale 1ns/10ps

module line_refill
	import cache_geom_pkg::*;
(
	input  logic wclk,
	input  logic rst_i,
	input  logic miss_i,
	input  logic [TAG_LSB+TAG_W-1:0] miss_pc_i,
	input  logic ack_i,
	output logic cyc_o,
	output logic stb_o,
	output logic [TAG_LSB+TAG_W-1:0] adr_o,
	output logic fill_we_o,
	output logic tag_clr_o,
	output logic [INDEX_W-1:0] clr_idx_o
);

typedef enum logic [1:0] {
	ST_INIT,	// one settle cycle out of reset
	ST_SWEEP,
	ST_IDLE,
	ST_FILL
} state_t;

state_t state;
logic [INDEX_W-1:0] clr_cnt;
logic [TAG_LSB+TAG_W-1:INDEX_LSB] line_q;
logic [$clog2(WORDS_PER_LINE)-1:0] word_q;
logic last_word;

assign last_word = 32'(word_q) == WORDS_PER_LINE - 1;

// stb stays up across the line, the address steps on every ack
assign cyc_o = (state == ST_FILL);
assign stb_o = (state == ST_FILL);
assign adr_o = {line_q, word_q, 2'b00};
assign fill_we_o = stb_o & ack_i;

assign tag_clr_o = (state == ST_SWEEP);
assign clr_idx_o = clr_cnt;

always_ff @(posedge wclk) begin
	if (rst_i) begin
		state <= ST_INIT;
		clr_cnt <= '0;
		word_q <= '0;
	end else begin
		case (state)
		ST_INIT:
			state <= ST_SWEEP;
		ST_SWEEP: begin
			clr_cnt <= clr_cnt + 1'b1;
			if (&clr_cnt)	// index 511 cleared this cycle
				state <= ST_IDLE;
		end
		ST_IDLE:
			if (miss_i) begin
				state <= ST_FILL;
				word_q <= '0;
			end
		ST_FILL:
			if (ack_i) begin
				word_q <= word_q + 1'b1;
				if (last_word)
					state <= ST_IDLE;
			end
		default:
			state <= ST_INIT;
		endcase
	end
end

// missed line base, held for the whole burst
always_ff @(posedge wclk) begin
	if (state == ST_IDLE && miss_i)
		line_q <= miss_pc_i[TAG_LSB+TAG_W-1:INDEX_LSB];
end

endmodule

/* hw/cache_geom_pkg.sv */
package cache_geom_pkg;

	localparam int BUS_W = 32;
	localparam int WORDS_PER_LINE = 4;

	// 512 lines of 16 bytes, direct mapped
	localparam int INDEX_W = 9;
	localparam int INDEX_LSB = 4;

	// address bits 31:13
	localparam int TAG_LSB = 13;
	localparam int TAG_W = 19;

endpackage

/* hw/fetch_geom_pkg.sv */
package fetch_geom_pkg;

	// fetch address
	localparam int PC_W = 32;

	// one instruction is 40 bits, three of them in a 128-bit line
	localparam int INSN_W = 40;
	localparam int SLOTS = 3;
	localparam int LINE_W = 128;	// top 8 bits unused

	// byte offset inside a 16-byte line
	localparam int LINE_OFS_W = 4;

	// low pc nibble of each slot
	localparam logic [LINE_OFS_W-1:0] SLOT1_OFS = 4'h5;
	localparam logic [LINE_OFS_W-1:0] SLOT2_OFS = 4'hA;

	localparam logic [PC_W-1:0] RESET_PC = 32'h0000_0000;

endpackage
